// File: design/bus_arbiter.sv
`timescale 1ns/10ps
`include "soc_defines.svh"

module bus_arbiter #(
  parameter int unsigned NUM_REQ = `SOC_NUM_MASTERS
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [NUM_REQ-1:0] req_i,
  input  logic               advance_i,  // commit the current grant
  output logic [NUM_REQ-1:0] gnt_o,      // one-hot
  output logic               any_o
);

  localparam int unsigned IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_REQ - 1);

  logic [IDX_W-1:0] ptr_q;    // highest priority index
  logic [IDX_W-1:0] win_idx;
  logic             found;

  // search starting at the pointer, wrapping around
  always_comb begin
    found   = 1'b0;
    win_idx = ptr_q;
    gnt_o   = '0;
    for (int k = 0; k < int'(NUM_REQ); k++) begin
      if (!found && req_i[(int'(ptr_q) + k) % int'(NUM_REQ)]) begin
        found   = 1'b1;
        win_idx = IDX_W'((int'(ptr_q) + k) % int'(NUM_REQ));
      end
    end
    if (found) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  assign any_o = found;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;                                          // master 0 first
    end else if (advance_i && found) begin
      ptr_q <= (win_idx == LAST_IDX) ? '0 : win_idx + 1'b1; // one past winner
    end
  end

endmodule

// File: design/bus_xbar.sv
`timescale 1ns/10ps
`include "soc_defines.svh"

module bus_xbar (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  soc_pkg::bus_req_t  [`SOC_NUM_MASTERS-1:0] m_req_i,
  output soc_pkg::bus_resp_t [`SOC_NUM_MASTERS-1:0] m_resp_o,
  output soc_pkg::bus_req_t                         ctrl_req_o,
  input  soc_pkg::bus_resp_t                        ctrl_resp_i,
  output soc_pkg::bus_req_t                         ram_req_o,
  input  soc_pkg::bus_resp_t                        ram_resp_i
);
  import soc_pkg::*;

  localparam int unsigned NUM_M = `SOC_NUM_MASTERS;
  localparam int unsigned IDX_W = (NUM_M > 1) ? $clog2(NUM_M) : 1;

  xbar_state_e      state_q;
  xbar_state_e      state_d;
  logic             idle;
  logic [NUM_M-1:0] arb_req;
  logic [NUM_M-1:0] arb_gnt;
  logic             arb_any;
  logic [IDX_W-1:0] win_idx;
  bus_req_t         win_req;
  logic             win_to_ctrl;
  bus_req_t         req_q;      // captured request payload
  logic             issue_q;    // slave valid pulse
  logic [IDX_W-1:0] owner_q;    // master that owns the open transaction
  logic             to_ctrl_q;  // decoded slave of the open transaction
  bus_resp_t        slv_resp;

  // ********************
  // arbitration
  // ********************
  for (genvar m = 0; m < NUM_M; m++) begin : g_req
    assign arb_req[m] = m_req_i[m].valid;
  end

  assign idle = (state_q == XBAR_IDLE);

  bus_arbiter #(
    .NUM_REQ(NUM_M)
  ) u_arbiter (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (arb_req),
    .advance_i(idle),     // pointer moves only when a grant is given
    .gnt_o    (arb_gnt),
    .any_o    (arb_any)
  );

  always_comb begin
    win_idx = '0;
    for (int m = 0; m < int'(NUM_M); m++) begin
      if (arb_gnt[m]) begin
        win_idx = IDX_W'(m);
      end
    end
    win_req     = m_req_i[win_idx];
    // control window, the ram port takes the rest
    win_to_ctrl = (win_req.addr >= `SOC_CTRL_BASE) &&
                  (win_req.addr < (`SOC_CTRL_BASE + `SOC_CTRL_SIZE));
  end

  // ********************
  // transaction FSM
  // ********************
  assign slv_resp = to_ctrl_q ? ctrl_resp_i : ram_resp_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      XBAR_IDLE: if (arb_any) state_d = XBAR_WAIT;
      XBAR_WAIT: if (slv_resp.rvalid) state_d = XBAR_IDLE;
      default:   state_d = XBAR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= XBAR_IDLE;
      issue_q   <= 1'b0;
      owner_q   <= '0;
      to_ctrl_q <= 1'b0;
    end else begin
      state_q <= state_d;
      issue_q <= idle && arb_any;   // one cycle after gnt
      if (idle && arb_any) begin
        owner_q   <= win_idx;
        to_ctrl_q <= win_to_ctrl;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (idle && arb_any) begin
      req_q <= win_req;
    end
  end

  always_comb begin
    ctrl_req_o       = req_q;
    ctrl_req_o.valid = issue_q && to_ctrl_q;
    ram_req_o        = req_q;
    ram_req_o.valid  = issue_q && !to_ctrl_q;
  end

  // response goes back in the cycle it arrives
  for (genvar m = 0; m < NUM_M; m++) begin : g_resp
    assign m_resp_o[m].gnt    = idle && arb_gnt[m];
    assign m_resp_o[m].rvalid = !idle && (owner_q == IDX_W'(m)) && slv_resp.rvalid;
    assign m_resp_o[m].err    = slv_resp.err;
    assign m_resp_o[m].rdata  = slv_resp.rdata;
  end

endmodule

// File: design/soc.sv
`timescale 1ns/10ps
`include "soc_defines.svh"

//   master 0   master 1
//      |          |
//   +-----------------+
//   |    bus_xbar     |
//   +-----------------+
//      |          |
//   soc_ctrl    ram port

module soc (
  input  logic                                          xtal_i,
  input  logic                                          arst_n_i,
  input  soc_pkg::bus_req_t  [`SOC_NUM_MASTERS-1:0]     m_req_i,
  output soc_pkg::bus_resp_t [`SOC_NUM_MASTERS-1:0]     m_resp_o,
  output soc_pkg::bus_req_t                             ram_req_o,
  input  soc_pkg::bus_resp_t                            ram_resp_i,
  output logic                                          ram_arst_no,
  input  logic [`SOC_NUM_CORE-1:0][`SOC_TEMP_WIDTH-1:0] core_temp_vec_i,
  output logic [`SOC_NUM_CORE-1:0][`SOC_XLEN-1:0]       boot_addr_vec_o,
  output logic [`SOC_NUM_CORE-1:0][`SOC_XLEN-1:0]       hart_id_vec_o,
  output logic [`SOC_NUM_CORE-1:0]                      core_clk_en_o,
  output logic [`SOC_NUM_CORE-1:0]                      core_arst_no
);
  import soc_pkg::*;

  bus_req_t  ctrl_req;   // xbar to control block
  bus_resp_t ctrl_resp;

  bus_xbar u_xbar (
    .clk_i      (xtal_i),
    .arst_n_i   (arst_n_i),
    .m_req_i    (m_req_i),
    .m_resp_o   (m_resp_o),
    .ctrl_req_o (ctrl_req),
    .ctrl_resp_i(ctrl_resp),
    .ram_req_o  (ram_req_o),     // default slave
    .ram_resp_i (ram_resp_i)
  );

  soc_ctrl u_soc_ctrl (
    .clk_i          (xtal_i),
    .arst_n_i       (arst_n_i),
    .req_i          (ctrl_req),
    .resp_o         (ctrl_resp),
    .core_temp_vec_i(core_temp_vec_i),
    .boot_addr_vec_o(boot_addr_vec_o),
    .hart_id_vec_o  (hart_id_vec_o),
    .core_clk_en_o  (core_clk_en_o),
    .core_arst_no   (core_arst_no),
    .ram_arst_no    (ram_arst_no)
  );

endmodule

// File: design/soc_ctrl.sv
`timescale 1ns/10ps
`include "soc_defines.svh"

module soc_ctrl (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  soc_pkg::bus_req_t                             req_i,
  output soc_pkg::bus_resp_t                            resp_o,
  input  logic [`SOC_NUM_CORE-1:0][`SOC_TEMP_WIDTH-1:0] core_temp_vec_i,
  output logic [`SOC_NUM_CORE-1:0][`SOC_XLEN-1:0]       boot_addr_vec_o,
  output logic [`SOC_NUM_CORE-1:0][`SOC_XLEN-1:0]       hart_id_vec_o,
  output logic [`SOC_NUM_CORE-1:0]                      core_clk_en_o,
  output logic [`SOC_NUM_CORE-1:0]                      core_arst_no,
  output logic                                          ram_arst_no
);
  import soc_pkg::*;

  localparam int unsigned NC     = `SOC_NUM_CORE;
  localparam int unsigned XLEN   = `SOC_XLEN;
  localparam int unsigned OFF_W  = $clog2(`SOC_CTRL_SIZE);
  localparam int unsigned CIDX_W = (NC > 1) ? $clog2(NC) : 1;
  localparam int unsigned CTRL_W = 2 * NC + 1;  // clk en, core rst, ram rst

  localparam logic [OFF_W-1:0] OFF_CTRL = OFF_W'(`SOC_REG_CORE_CTRL);
  localparam logic [OFF_W-1:0] OFF_TEMP = OFF_W'(`SOC_REG_TEMP);
  localparam logic [OFF_W-1:0] OFF_BOOT = OFF_W'(`SOC_REG_BOOT_BASE);
  localparam logic [OFF_W-1:0] OFF_HART = OFF_W'(`SOC_REG_HART_BASE);
  localparam logic [OFF_W-1:0] OFF_SPAN = OFF_W'(4 * NC);  // one word per core

  logic [OFF_W-1:0]          off;
  logic [OFF_W-1:0]          boot_rel;
  logic [OFF_W-1:0]          hart_rel;
  logic [CIDX_W-1:0]         boot_sel;
  logic [CIDX_W-1:0]         hart_sel;
  logic                      hit_ctrl;
  logic                      hit_temp;
  logic                      hit_boot;
  logic                      hit_hart;
  logic                      acc_err;
  logic                      wr_en;
  logic [XLEN-1:0]           rdata;
  logic [CTRL_W-1:0]         core_ctrl_q;
  logic [NC-1:0][XLEN-1:0]   boot_q;
  logic [NC-1:0][XLEN-1:0]   hart_q;
  logic                      rvalid_q;
  logic                      err_q;
  logic [XLEN-1:0]           rdata_q;

  // ********************
  // offset decode
  // ********************
  always_comb begin
    off      = OFF_W'(req_i.addr - `SOC_CTRL_BASE);
    boot_rel = off - OFF_BOOT;
    hart_rel = off - OFF_HART;
    boot_sel = boot_rel[CIDX_W+1:2];
    hart_sel = hart_rel[CIDX_W+1:2];
    hit_ctrl = (off == OFF_CTRL);
    hit_temp = (off == OFF_TEMP);
    hit_boot = (off[1:0] == 2'b00) && (off >= OFF_BOOT) && (off < OFF_BOOT + OFF_SPAN);
    hit_hart = (off[1:0] == 2'b00) && (off >= OFF_HART) && (off < OFF_HART + OFF_SPAN);
    // temp is read only
    acc_err  = !(hit_ctrl || hit_temp || hit_boot || hit_hart) ||
               (hit_temp && (req_i.op == OP_WRITE));
    wr_en    = req_i.valid && (req_i.op == OP_WRITE) && !acc_err;

    rdata = '0;
    if (hit_ctrl) begin
      rdata = XLEN'(core_ctrl_q);
    end else if (hit_temp) begin
      rdata = XLEN'(core_temp_vec_i);  // core 0 in the low byte
    end else if (hit_boot) begin
      rdata = boot_q[boot_sel];
    end else if (hit_hart) begin
      rdata = hart_q[hart_sel];
    end
  end

  // ********************
  // registers
  // ********************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      core_ctrl_q <= '0;                        // cores and ram held in reset
      for (int c = 0; c < int'(NC); c++) begin
        boot_q[c] <= `SOC_BOOT_DEFAULT;
        hart_q[c] <= XLEN'(c);                  // hart id is the core index
      end
    end else if (wr_en) begin
      if (hit_ctrl) core_ctrl_q <= req_i.wdata[CTRL_W-1:0];
      if (hit_boot) boot_q[boot_sel] <= req_i.wdata;
      if (hit_hart) hart_q[hart_sel] <= req_i.wdata;
    end
  end

  // answer one cycle after the request pulse
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      err_q   <= acc_err;
      rdata_q <= (acc_err || (req_i.op == OP_WRITE)) ? '0 : rdata;  // writes return 0
    end
  end

  assign resp_o.gnt    = req_i.valid;  // always ready
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = err_q;
  assign resp_o.rdata  = rdata_q;

  assign core_clk_en_o   = core_ctrl_q[NC-1:0];
  assign core_arst_no    = core_ctrl_q[2*NC-1:NC];
  assign ram_arst_no     = core_ctrl_q[2*NC];
  assign boot_addr_vec_o = boot_q;
  assign hart_id_vec_o   = hart_q;

endmodule

// File: design/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ********************
// bus and system sizes
// ********************
`define SOC_XLEN          32                 // address and data width
`define SOC_NUM_MASTERS   2                  // external master ports
`define SOC_NUM_CORE      4                  // cores served by soc_ctrl
`define SOC_TEMP_WIDTH    8                  // one temperature sensor value

// ********************
// address map
// ********************
`define SOC_CTRL_BASE     32'h1000_0000      // control block window
`define SOC_CTRL_SIZE     32'h0000_1000      // 4 KiB, everything else is ram

// control block register offsets
`define SOC_REG_CORE_CTRL 32'h0000_0000      // clk enables, resets
`define SOC_REG_TEMP      32'h0000_0004      // packed sensor bytes, read only
`define SOC_REG_BOOT_BASE 32'h0000_0010      // one word per core
`define SOC_REG_HART_BASE 32'h0000_0020      // one word per core

`define SOC_BOOT_DEFAULT  32'h8000_0000      // boot address after reset

`endif

// File: design/soc_pkg.sv
`include "soc_defines.svh"

package soc_pkg;

  // ********************
  // bus encodings
  // ********************
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  // request from a master, held until gnt
  typedef struct packed {
    logic                 valid;
    bus_op_e              op;
    logic [`SOC_XLEN-1:0] addr;
    logic [`SOC_XLEN-1:0] wdata;
  } bus_req_t;

  // gnt and rvalid are single cycle pulses
  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;
    logic                 err;    // undefined register or illegal write
    logic [`SOC_XLEN-1:0] rdata;
  } bus_resp_t;

  // ********************
  // crossbar FSM
  // ********************
  typedef enum logic {
    XBAR_IDLE = 1'b0,  // no transaction open
    XBAR_WAIT = 1'b1   // request issued, waiting for the slave rvalid
  } xbar_state_e;

endpackage

// File: filelist.f
+incdir+design
design/soc_pkg.sv
design/bus_arbiter.sv
design/bus_xbar.sv
design/soc_ctrl.sv
design/soc.sv
sim/tb_ram_model.sv
sim/tb_soc.sv

// File: sim/tb_ram_model.sv
`timescale 1ns/10ps
`include "soc_defines.svh"

module tb_ram_model (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  soc_pkg::bus_req_t  req_i,
  input  logic [2:0]         lat_i,    // answer 1 to 4 cycles after the request
  output soc_pkg::bus_resp_t resp_o
);
  import soc_pkg::*;

  logic [`SOC_XLEN-1:0] mem [logic [`SOC_XLEN-1:0]];
  int unsigned          cnt;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_o <= '0;
      cnt    <= 0;
    end else begin
      resp_o.rvalid <= 1'b0;
      if (req_i.valid) begin
        cnt           <= lat_i - 1;
        resp_o.rvalid <= (lat_i == 3'd1);                  // latency 1 answers right away
        resp_o.err    <= 1'b0;
        if (req_i.op == OP_WRITE) begin
          mem[req_i.addr] = req_i.wdata;
          resp_o.rdata   <= '0;                          // writes return 0
        end else if (mem.exists(req_i.addr)) begin
          resp_o.rdata <= mem[req_i.addr];
        end else begin
          resp_o.rdata <= {req_i.addr[15:0], req_i.addr[31:16]} ^ 32'hc3a5_5a3c;  // unwritten
        end
      end else if (cnt != 0) begin
        cnt <= cnt - 1;
        if (cnt == 1) resp_o.rvalid <= 1'b1;
      end
    end
  end

endmodule

// File: sim/tb_soc.sv
`timescale 1ns/10ps
`include "soc_defines.svh"

module tb_soc;
  import soc_pkg::*;

  localparam int NM = `SOC_NUM_MASTERS;
  localparam int NC = `SOC_NUM_CORE;
  localparam logic [31:0] CTRL = `SOC_CTRL_BASE;

  logic                                clk = 1'b0;
  logic                                arst_n = 1'b0;
  bus_req_t  [NM-1:0]                  m_req = '0;
  bus_resp_t [NM-1:0]                  m_resp;
  bus_req_t                            ram_req;
  bus_resp_t                           ram_resp;
  logic                                ram_arst_n;
  logic [2:0]                          ram_lat = 3'd1;
  logic [NC-1:0][`SOC_TEMP_WIDTH-1:0]  temp = '0;
  logic [NC-1:0][31:0]                 boot_vec;
  logic [NC-1:0][31:0]                 hart_vec;
  logic [NC-1:0]                       clk_en;
  logic [NC-1:0]                       core_arst_n;

  logic [31:0]         lcg = 32'h27df9e75;
  logic [2*NC:0]       sh_ctrl;                   // shadow of CORE_CTRL
  logic [NC-1:0][31:0] sh_boot;
  logic [NC-1:0][31:0] sh_hart;
  logic [31:0]         sh_ram [logic [31:0]];
  int                  cyc = 0;
  int                  n_issued = 0;
  int                  val_errs = 0;
  int                  proto_errs = 0;
  int                  rr_ptr = 0;                // expected top priority master
  int                  contests = 0;
  logic                open_q = 1'b0;
  int                  open_m;
  int                  gnt_cyc;
  bus_req_t            open_req;
  logic [32:0]         open_exp;                  // {err, rdata}

  initial begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  soc DUT (
    .xtal_i(clk), .arst_n_i(arst_n), .m_req_i(m_req), .m_resp_o(m_resp),
    .ram_req_o(ram_req), .ram_resp_i(ram_resp), .ram_arst_no(ram_arst_n),
    .core_temp_vec_i(temp), .boot_addr_vec_o(boot_vec), .hart_id_vec_o(hart_vec),
    .core_clk_en_o(clk_en), .core_arst_no(core_arst_n)
  );

  tb_ram_model u_ram (
    .clk_i(clk), .arst_n_i(arst_n), .req_i(ram_req), .lat_i(ram_lat), .resp_o(ram_resp)
  );

  // ********************
  // model
  // ********************
  function automatic logic [31:0] next_rand();
    lcg = lcg * 32'd1664525 + 32'd1013904223;
    return lcg;
  endfunction

  function automatic bit in_ctrl_window(input logic [31:0] a);
    return (a >= CTRL) && (a < CTRL + `SOC_CTRL_SIZE);
  endfunction

  // expected {err, rdata}, the shadows follow the writes
  function automatic logic [32:0] expected_resp(input bus_req_t r);
    logic [31:0] off;
    logic        wr;
    off = r.addr - CTRL;
    wr  = (r.op == OP_WRITE);
    if (!in_ctrl_window(r.addr)) begin
      if (wr) sh_ram[r.addr] = r.wdata;
      if (wr) return '0;
      if (sh_ram.exists(r.addr)) return {1'b0, sh_ram[r.addr]};
      return {1'b0, {r.addr[15:0], r.addr[31:16]} ^ 32'hc3a5_5a3c};
    end
    if (off == `SOC_REG_CORE_CTRL) begin
      if (wr) sh_ctrl = r.wdata[2*NC:0];
      return wr ? '0 : {1'b0, 32'(sh_ctrl)};
    end
    if (off == `SOC_REG_TEMP) return wr ? {1'b1, 32'h0} : {1'b0, 32'(temp)};  // read only
    if (off[1:0] == 2'b00 && off >= `SOC_REG_BOOT_BASE && off < `SOC_REG_BOOT_BASE + 4 * NC) begin
      if (wr) sh_boot[(off - `SOC_REG_BOOT_BASE) / 4] = r.wdata;
      return wr ? '0 : {1'b0, sh_boot[(off - `SOC_REG_BOOT_BASE) / 4]};
    end
    if (off[1:0] == 2'b00 && off >= `SOC_REG_HART_BASE && off < `SOC_REG_HART_BASE + 4 * NC) begin
      if (wr) sh_hart[(off - `SOC_REG_HART_BASE) / 4] = r.wdata;
      return wr ? '0 : {1'b0, sh_hart[(off - `SOC_REG_HART_BASE) / 4]};
    end
    return {1'b1, 32'h0};                         // undefined offset
  endfunction

  task automatic check_ctrl_ports(input string where);
    assert (clk_en == sh_ctrl[NC-1:0] && core_arst_n == sh_ctrl[2*NC-1:NC] &&
            ram_arst_n == sh_ctrl[2*NC] && boot_vec == sh_boot && hart_vec == sh_hart)
    else begin
      $display("** Error [%0t] %s: en=%h rst_n=%h ram_rst_n=%b boot=%h hart=%h, ctrl %h",
               $time, where, clk_en, core_arst_n, ram_arst_n, boot_vec, hart_vec, sh_ctrl);
      val_errs++;
    end
  endtask

  // one master access, request held until gnt, returns after rvalid
  task automatic bus_access(input int m, input bus_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
    @(posedge clk);
    #1;
    ram_lat  = 3'(1 + next_rand() % 4);
    m_req[m] = '{valid: 1'b1, op: op, addr: addr, wdata: wdata};
    n_issued++;
    do @(negedge clk); while (!m_resp[m].gnt);
    @(posedge clk);
    #1;
    m_req[m].valid = 1'b0;
    do @(negedge clk); while (!m_resp[m].rvalid);
  endtask

  // ********************
  // compare process
  // ********************
  always @(negedge clk) begin : compare
    int win;
    int n_req;
    if (arst_n) begin
      for (int m = 0; m < NM; m++) begin
        if (m_resp[m].rvalid) begin
          assert (open_q && open_m == m) else begin
            $display("rvalid on master %0d without an open transaction", m);
            proto_errs++;
          end
          if (open_q && open_m == m) begin
            assert (m_resp[m].err == open_exp[32] && m_resp[m].rdata == open_exp[31:0])
            else begin
              $display("** Error [%0t] m%0d %s %h: err=%b data=%h, expected err=%b data=%h",
                       $time, m, (open_req.op == OP_WRITE) ? "write" : "read", open_req.addr,
                       m_resp[m].err, m_resp[m].rdata, open_exp[32], open_exp[31:0]);
              val_errs++;
            end
            if (in_ctrl_window(open_req.addr)) begin
              assert (cyc - gnt_cyc == 2) else begin
                $display("** Error [%0t] control rvalid %0d cycles after gnt", $time,
                         cyc - gnt_cyc);
                val_errs++;
              end
            end
            check_ctrl_ports("after rvalid");
            open_q = 1'b0;
          end
        end
      end
      if (ram_req.valid) begin
        assert (open_q && !in_ctrl_window(open_req.addr) && cyc == gnt_cyc + 1 &&
                ram_req.op == open_req.op && ram_req.addr == open_req.addr &&
                (ram_req.op == OP_READ || ram_req.wdata == open_req.wdata))
        else begin
          $display("** Error [%0t] unexpected ram request %h", $time, ram_req);
          val_errs++;
        end
      end
      for (int m = 0; m < NM; m++) begin
        if (m_resp[m].gnt) begin
          win   = -1;
          n_req = 0;
          for (int k = 0; k < NM; k++) begin
            n_req += m_req[k].valid;
            if (win < 0 && m_req[(rr_ptr + k) % NM].valid) win = (rr_ptr + k) % NM;
          end
          assert (!open_q) else begin
            $display("gnt to master %0d while a transaction is still open", m);
            proto_errs++;
          end
          assert (m == win) else begin
            $display("** Error [%0t] gnt to master %0d, expected %0d", $time, m, win);
            val_errs++;
          end
          if (n_req > 1) contests++;
          rr_ptr   = (m + 1) % NM;
          open_q   = 1'b1;
          open_m   = m;
          open_req = m_req[m];
          gnt_cyc  = cyc;
          open_exp = expected_resp(m_req[m]);
        end
      end
    end
  end

  initial begin
    wait (cyc >= 40 * n_issued + 200);
    $display("timeout: run stopped after %0d cycles, %0d transactions issued", cyc, n_issued);
    $display("TEST FAILED");
    $finish;
  end

  // ********************
  // stimulus
  // ********************
  initial begin
    logic [31:0] bad_off [0:5];
    logic [31:0] ram_addr [0:15];
    bad_off = '{32'h08, 32'h0c, 32'h12, 32'h30, 32'h800, 32'hffc};
    sh_ctrl = '0;
    for (int c = 0; c < NC; c++) begin
      sh_boot[c] = `SOC_BOOT_DEFAULT;
      sh_hart[c] = c;
    end
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    for (int m = 0; m < NM; m++) begin
      assert (!m_resp[m].gnt && !m_resp[m].rvalid) else begin
        $display("** Error [%0t] master %0d strobes active after reset", $time, m);
        val_errs++;
      end
    end
    assert (!ram_req.valid) else begin
      $display("** Error [%0t] ram request active after reset", $time);
      val_errs++;
    end
    check_ctrl_ports("after reset");

    for (int c = 0; c < NC; c++) begin
      bus_access(c % NM, OP_WRITE, CTRL + `SOC_REG_BOOT_BASE + 4 * c, next_rand());
      bus_access(c % NM, OP_WRITE, CTRL + `SOC_REG_HART_BASE + 4 * c, next_rand());
    end
    for (int c = 0; c < NC; c++) begin
      bus_access((c + 1) % NM, OP_READ, CTRL + `SOC_REG_BOOT_BASE + 4 * c, '0);
      bus_access(c % NM, OP_READ, CTRL + `SOC_REG_HART_BASE + 4 * c, '0);
    end
    for (int b = 0; b <= 2 * NC; b++) begin             // walk each control bit
      bus_access(b % NM, OP_WRITE, CTRL + `SOC_REG_CORE_CTRL, 32'h1 << b);
      bus_access(0, OP_READ, CTRL + `SOC_REG_CORE_CTRL, '0);
    end
    repeat (4) begin
      bus_access(1, OP_WRITE, CTRL + `SOC_REG_CORE_CTRL, next_rand());
      bus_access(0, OP_READ, CTRL + `SOC_REG_CORE_CTRL, '0);
    end
    repeat (3) begin
      @(posedge clk);
      #1;
      temp = next_rand();
      bus_access(1, OP_READ, CTRL + `SOC_REG_TEMP, '0);
    end
    bus_access(0, OP_WRITE, CTRL + `SOC_REG_TEMP, next_rand());
    for (int i = 0; i < 6; i++) begin
      bus_access(i % NM, OP_WRITE, CTRL + bad_off[i], next_rand());
      bus_access(i % NM, OP_READ, CTRL + bad_off[i], '0);
    end

    // ram traffic from both masters at once
    for (int i = 0; i < 16; i++) begin
      ram_addr[i] = next_rand() & 32'hffff_fffc;
      if (in_ctrl_window(ram_addr[i])) ram_addr[i] ^= 32'h8000_0000;
    end
    fork
      for (int i = 0; i < 8; i++) bus_access(0, OP_WRITE, ram_addr[i], next_rand());
      for (int i = 8; i < 16; i++) bus_access(1, OP_WRITE, ram_addr[i], next_rand());
    join
    fork
      for (int i = 8; i < 17; i++) bus_access(0, OP_READ, ram_addr[i % 16] ^ (i / 16), '0);
      for (int i = 0; i < 9; i++) bus_access(1, OP_READ, ram_addr[i] ^ ((i / 8) << 12), '0);
    join

    contests = 0;
    fork
      repeat (6) bus_access(0, OP_READ, CTRL + `SOC_REG_HART_BASE, '0);
      repeat (6) bus_access(1, OP_READ, CTRL + `SOC_REG_BOOT_BASE + 4, '0);
    join
    assert (contests >= 10) else begin
      $display("arbitration saw only %0d contested grants", contests);
      proto_errs++;
    end

    repeat (2) @(posedge clk);
    assert (!open_q) else begin
      $display("a transaction was still open at the end of the run");
      proto_errs++;
    end
    $display("%0d transactions: %0d value errors, %0d protocol errors", n_issued, val_errs,
             proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
